/* verilog/ex_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the execute slice of the 16-bit core
// Struct fields are packed MSB first in the order listed
// ADDR_MAX bounds the ADDR_W parameter of the store path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ex_pkg;

localparam int DATA_W   = 16;
localparam int REG_N    = 8;
localparam int REG_W    = 3;
localparam int ADDR_MAX = 24;

typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_LDI  = 4'h1,
    OP_MOV  = 4'h2,
    OP_ADD  = 4'h3,
    OP_SUB  = 4'h4,
    OP_AND  = 4'h5,
    OP_OR   = 4'h6,
    OP_XOR  = 4'h7,
    OP_ST8  = 4'h8,
    OP_ST16 = 4'h9
} ex_op_e;

// Decoder word, 26 bits
typedef struct packed {
    ex_op_e              op;
    logic [REG_W-1:0]    dst;
    logic [REG_W-1:0]    src;
    logic [DATA_W-1:0]   imm;
} ex_inst_t;

typedef struct packed {
    logic z;
    logic n;
    logic c;
    logic v;
} ex_flags_t;

// Register write request, 25 bits
typedef struct packed {
    logic                we;
    logic [REG_W-1:0]    dst;
    logic [DATA_W-1:0]   data;
    logic                flag_we;
    ex_flags_t           flags;
} ex_wr_t;

// Store request, 19 bits; be[1] is the odd byte lane
typedef struct packed {
    logic                en;
    logic [1:0]          be;
    logic [DATA_W-1:0]   data;
} ex_store_t;

endpackage

/* verilog/ex_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Eight 16-bit registers, all cleared by reset
// Read ports forward a pending write from writeback
// Dump port is not forwarded; dmp_addr[0] high selects the
// high byte of the register picked by dmp_addr[3:1]
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ex_regs(
    input  logic                        clk,
    input  logic                        reset,

    input  logic [ex_pkg::REG_W-1:0]    rd_src,
    input  logic [ex_pkg::REG_W-1:0]    rd_dst,
    input  ex_pkg::ex_wr_t              reg_wr,
    output logic [ex_pkg::DATA_W-1:0]   src_val,
    output logic [ex_pkg::DATA_W-1:0]   dst_val,

    // Register dump
    input  logic [3:0]                  dmp_addr,
    output logic [7:0]                  dmp_din
);

logic [ex_pkg::DATA_W-1:0] regs [ex_pkg::REG_N];
logic [ex_pkg::DATA_W-1:0] dmp_word;

always_ff @(posedge clk) begin
    if (reset) begin
        for (int i = 0; i < ex_pkg::REG_N; i++) begin
            regs[i] <= '0;
        end
    end else if (reg_wr.we) begin
        regs[reg_wr.dst] <= reg_wr.data;
    end
end

// Bypass so that back-to-back dependent instructions see the new value
always_comb begin
    if (reg_wr.we && reg_wr.dst == rd_src) begin
        src_val = reg_wr.data;
    end else begin
        src_val = regs[rd_src];
    end
end

always_comb begin
    if (reg_wr.we && reg_wr.dst == rd_dst) begin
        dst_val = reg_wr.data;
    end else begin
        dst_val = regs[rd_dst];
    end
end

// Dump reads the stored bank only
always_comb begin
    dmp_word = regs[dmp_addr[3:1]];
    if (dmp_addr[0]) begin
        dmp_din = dmp_word[15:8];
    end else begin
        dmp_din = dmp_word[7:0];
    end
end

endmodule

/* verilog/ex_alu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-cycle ALU, result registered one cycle after strobe
// Flags only change on ADD, SUB, AND, OR and XOR
// SUB reports borrow in c
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ex_alu(
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        inst_stb,
    input  ex_pkg::ex_inst_t            inst,
    input  logic [ex_pkg::DATA_W-1:0]   src_val,
    input  logic [ex_pkg::DATA_W-1:0]   dst_val,

    output ex_pkg::ex_wr_t              alu_res
);

localparam int MSB = ex_pkg::DATA_W - 1;

logic [ex_pkg::DATA_W:0]   sum, dif;
logic [ex_pkg::DATA_W-1:0] res;
logic                      we_nx, flag_nx, c_nx, v_nx;

always_comb begin
    sum     = {1'b0, dst_val} + {1'b0, src_val};
    dif     = {1'b0, dst_val} - {1'b0, src_val};
    res     = '0;
    we_nx   = 1'b0;
    flag_nx = 1'b0;
    c_nx    = 1'b0;
    v_nx    = 1'b0;
    case (inst.op)
        ex_pkg::OP_LDI: begin
            res   = inst.imm;
            we_nx = 1'b1;
        end
        ex_pkg::OP_MOV: begin
            res   = src_val;
            we_nx = 1'b1;
        end
        ex_pkg::OP_ADD: begin
            res     = sum[MSB:0];
            c_nx    = sum[ex_pkg::DATA_W];
            // Same-sign operands giving a result of the other sign
            v_nx    = (dst_val[MSB] == src_val[MSB]) && (res[MSB] != dst_val[MSB]);
            we_nx   = 1'b1;
            flag_nx = 1'b1;
        end
        ex_pkg::OP_SUB: begin
            res     = dif[MSB:0];
            c_nx    = dif[ex_pkg::DATA_W];
            v_nx    = (dst_val[MSB] != src_val[MSB]) && (res[MSB] != dst_val[MSB]);
            we_nx   = 1'b1;
            flag_nx = 1'b1;
        end
        ex_pkg::OP_AND, ex_pkg::OP_OR, ex_pkg::OP_XOR: begin
            if (inst.op == ex_pkg::OP_AND) begin
                res = dst_val & src_val;
            end else if (inst.op == ex_pkg::OP_OR) begin
                res = dst_val | src_val;
            end else begin
                res = dst_val ^ src_val;
            end
            we_nx   = 1'b1;
            flag_nx = 1'b1;
        end
        default: begin
            // NOP and stores leave the bank alone
            res = '0;
        end
    endcase
end

always_ff @(posedge clk) begin
    if (reset) begin
        alu_res <= '0;
    end else begin
        alu_res.we      <= inst_stb & we_nx;
        alu_res.dst     <= inst.dst;
        alu_res.data    <= res;
        alu_res.flag_we <= inst_stb & flag_nx;
        alu_res.flags   <= '{z: (res == '0), n: res[MSB], c: c_nx, v: v_nx};
    end
end

// Decoder only sends defined opcodes
assert property (@(posedge clk) disable iff (reset)
    inst_stb |-> inst.op <= ex_pkg::OP_ST16);

endmodule

/* verilog/ex_idxaddr.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Indexed store addresser: src + sign-extended imm
// ADDR_W must lie between DATA_W and ADDR_MAX
// Address wraps modulo 2**ADDR_W; ST16 forces bit 0 low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ex_idxaddr #(
    parameter int ADDR_W = 24
)(
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        inst_stb,
    input  ex_pkg::ex_inst_t            inst,
    input  logic [ex_pkg::DATA_W-1:0]   src_val,
    input  logic [ex_pkg::DATA_W-1:0]   dst_val,

    output logic [ADDR_W-1:0]           st_addr,
    output ex_pkg::ex_store_t           st_req
);

if (ADDR_W < ex_pkg::DATA_W || ADDR_W > ex_pkg::ADDR_MAX) begin : g_bad_addr_w
    $error("ex_idxaddr: ADDR_W out of range");
end

logic [ADDR_W-1:0] ea;
logic              is_st8, is_st16;

assign ea      = ADDR_W'(src_val) + ADDR_W'($signed(inst.imm));
assign is_st8  = inst.op == ex_pkg::OP_ST8;
assign is_st16 = inst.op == ex_pkg::OP_ST16;

always_ff @(posedge clk) begin
    if (reset) begin
        st_req <= '0;
    end else begin
        st_req.en <= inst_stb & (is_st8 | is_st16);
        if (is_st16) begin
            st_req.be   <= 2'b11;
            st_req.data <= dst_val;
        end else begin
            // Byte store goes on the lane picked by the address LSB
            st_req.be   <= ea[0] ? 2'b10 : 2'b01;
            st_req.data <= ea[0] ? {dst_val[7:0], 8'h00} : {8'h00, dst_val[7:0]};
        end
    end
end

always_ff @(posedge clk) begin
    st_addr <= is_st16 ? {ea[ADDR_W-1:1], 1'b0} : ea;
end

endmodule

/* verilog/ex_wb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Writeback: register write, flags and the RAM write port
// ram_we is high for exactly one cycle per store
// RAM address and data are only meaningful while ram_we != 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ex_wb #(
    parameter int ADDR_W = 24
)(
    input  logic                        clk,
    input  logic                        reset,

    input  ex_pkg::ex_wr_t              alu_res,
    input  logic [ADDR_W-1:0]           st_addr,
    input  ex_pkg::ex_store_t           st_req,

    output ex_pkg::ex_wr_t              reg_wr,
    output ex_pkg::ex_flags_t           flags,

    // RAM write port
    output logic [ADDR_W-1:0]           ram_addr,
    output logic [ex_pkg::DATA_W-1:0]   ram_din,
    output logic [1:0]                  ram_we
);

// Bank write happens in the cycle after the strobe
assign reg_wr = alu_res;

always_ff @(posedge clk) begin
    if (reset) begin
        flags <= '0;
    end else if (alu_res.flag_we) begin
        flags <= alu_res.flags;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        ram_we <= 2'b00;
    end else begin
        ram_we <= st_req.en ? st_req.be : 2'b00;
    end
end

always_ff @(posedge clk) begin
    ram_addr <= st_addr;
    ram_din  <= st_req.data;
end

// The ALU and the addresser never claim the same instruction
assert property (@(posedge clk) disable iff (reset)
    !(alu_res.we && st_req.en));

endmodule

/* verilog/ex_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute slice top: register bank, ALU, addresser, writeback
// One instruction per inst_stb, no back-pressure
// Flags visible two cycles after the strobe, stores likewise
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ex_core #(
    parameter int ADDR_W = 24
)(
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        inst_stb,
    input  ex_pkg::ex_inst_t            inst,

    output logic [ADDR_W-1:0]           ram_addr,
    output logic [ex_pkg::DATA_W-1:0]   ram_din,
    output logic [1:0]                  ram_we,

    output ex_pkg::ex_flags_t           flags,

    // Register dump
    input  logic [3:0]                  dmp_addr,
    output logic [7:0]                  dmp_din
);

logic [ex_pkg::DATA_W-1:0] src_val, dst_val;
ex_pkg::ex_wr_t            alu_res, reg_wr;
ex_pkg::ex_store_t         st_req;
logic [ADDR_W-1:0]         st_addr;

ex_regs u_regs(
    .clk        ( clk           ),
    .reset      ( reset         ),
    .rd_src     ( inst.src      ),
    .rd_dst     ( inst.dst      ),
    .reg_wr     ( reg_wr        ),
    .src_val    ( src_val       ),
    .dst_val    ( dst_val       ),
    .dmp_addr   ( dmp_addr      ),
    .dmp_din    ( dmp_din       )
);

ex_alu u_alu(
    .clk        ( clk           ),
    .reset      ( reset         ),
    .inst_stb   ( inst_stb      ),
    .inst       ( inst          ),
    .src_val    ( src_val       ),
    .dst_val    ( dst_val       ),
    .alu_res    ( alu_res       )
);

ex_idxaddr #(.ADDR_W(ADDR_W)) u_idxaddr(
    .clk        ( clk           ),
    .reset      ( reset         ),
    .inst_stb   ( inst_stb      ),
    .inst       ( inst          ),
    .src_val    ( src_val       ),
    .dst_val    ( dst_val       ),
    .st_addr    ( st_addr       ),
    .st_req     ( st_req        )
);

ex_wb #(.ADDR_W(ADDR_W)) u_wb(
    .clk        ( clk           ),
    .reset      ( reset         ),
    .alu_res    ( alu_res       ),
    .st_addr    ( st_addr       ),
    .st_req     ( st_req        ),
    .reg_wr     ( reg_wr        ),
    .flags      ( flags         ),
    .ram_addr   ( ram_addr      ),
    .ram_din    ( ram_din       ),
    .ram_we     ( ram_we        )
);

endmodule

/* verif/tb_ex_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random testbench for ex_core built with ADDR_W = 20
// Model runs at the strobe; flags and stores compared at N+2
// Stops at the first mismatch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_ex_core;

typedef struct packed {
    logic [31:0]       due;
    logic [19:0]       addr;
    ex_pkg::ex_store_t st;
} exp_store_t;

logic              clk, reset, inst_stb;
ex_pkg::ex_inst_t  inst;
logic [3:0]        dmp_addr;
logic [7:0]        dmp_din;
logic [19:0]       ram_addr;
logic [15:0]       ram_din;
logic [1:0]        ram_we;
ex_pkg::ex_flags_t flags, model_flags, flags_d1, flags_d2;
logic [15:0]       model_regs [8];
exp_store_t        st_q [$];
logic [31:0]       lfsr;
int                cyc;

ex_core #(.ADDR_W(20)) ex_core_inst(
    .clk      ( clk      ),
    .reset    ( reset    ),
    .inst_stb ( inst_stb ),
    .inst     ( inst     ),
    .ram_addr ( ram_addr ),
    .ram_din  ( ram_din  ),
    .ram_we   ( ram_we   ),
    .flags    ( flags    ),
    .dmp_addr ( dmp_addr ),
    .dmp_din  ( dmp_din  )
);

initial clk = 1'b0;
always #50 clk = ~clk;

initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
end

task automatic stop_sim();
    $display("Simulation failed");
    $fatal(1);
endtask

task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
    stop_sim();
endtask

task automatic check_flags(input ex_pkg::ex_flags_t exp);
    if (flags !== exp) mismatch("flags", 32'(exp), 32'(flags));
endtask

task automatic check_store(input logic [19:0] addr, input ex_pkg::ex_store_t exp);
    logic [1:0] exp_we;
    exp_we = exp.en ? exp.be : 2'b00;
    if (ram_we !== exp_we) mismatch("ram_we", 32'(exp_we), 32'(ram_we));
    if (exp.en && ram_addr !== addr) mismatch("ram_addr", 32'(addr), 32'(ram_addr));
    if (exp.en && ram_din !== exp.data) mismatch("ram_din", 32'(exp.data), 32'(ram_din));
endtask

task automatic check_dump(input logic [3:0] a, input logic [7:0] exp);
    if (dmp_din !== exp) mismatch($sformatf("dmp_din[%0d]", a), 32'(exp), 32'(dmp_din));
endtask

// Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        v = {v[30:0], lfsr[0]};
        lfsr = lfsr_step(lfsr);
    end
    return v;
endfunction

function automatic ex_pkg::ex_inst_t rand_inst();
    ex_pkg::ex_inst_t ins;
    ins.op  = ex_pkg::ex_op_e'(4'(take_bits(4) % 32'd10));
    ins.dst = 3'(take_bits(3));
    ins.src = 3'(take_bits(3));
    ins.imm = 16'(take_bits(16));
    return ins;
endfunction

task automatic model_exec(input ex_pkg::ex_inst_t ins);
    logic [15:0] d, s, r;
    logic [31:0] ea;
    int          sg;
    exp_store_t  e;
    d = model_regs[ins.dst];
    s = model_regs[ins.src];
    r = '0;
    case (ins.op)
        ex_pkg::OP_LDI: model_regs[ins.dst] = ins.imm;
        ex_pkg::OP_MOV: model_regs[ins.dst] = s;
        ex_pkg::OP_ADD: begin
            r = d + s;
            model_flags.c = (32'(d) + 32'(s)) > 32'd65535;
            sg = int'($signed(d)) + int'($signed(s));
            model_flags.v = sg > 32767 || sg < -32768;
        end
        ex_pkg::OP_SUB: begin
            r = d - s;
            model_flags.c = d < s;
            sg = int'($signed(d)) - int'($signed(s));
            model_flags.v = sg > 32767 || sg < -32768;
        end
        ex_pkg::OP_AND: r = d & s;
        ex_pkg::OP_OR:  r = d | s;
        ex_pkg::OP_XOR: r = d ^ s;
        ex_pkg::OP_ST8, ex_pkg::OP_ST16: begin
            ea = {16'h0, s} + {{16{ins.imm[15]}}, ins.imm};
            e.due = 32'(cyc + 2);
            e.addr = ea[19:0];
            e.st.en = 1'b1;
            // Low byte of dst moves up one lane for an odd address
            e.st.be = 2'b01 << ea[0];
            e.st.data = {8'h00, d[7:0]} << (ea[0] ? 8 : 0);
            if (ins.op == ex_pkg::OP_ST16) begin
                e.addr[0] = 1'b0;
                e.st.be = 2'b11;
                e.st.data = d;
            end
            st_q.push_back(e);
        end
        default: ;
    endcase
    if (ins.op inside {ex_pkg::OP_AND, ex_pkg::OP_OR, ex_pkg::OP_XOR}) begin
        model_flags.c = 1'b0;
        model_flags.v = 1'b0;
    end
    if (ins.op inside {ex_pkg::OP_ADD, ex_pkg::OP_SUB, ex_pkg::OP_AND,
                       ex_pkg::OP_OR, ex_pkg::OP_XOR}) begin
        model_regs[ins.dst] = r;
        model_flags.z = r == 16'h0;
        model_flags.n = r[15];
    end
endtask

// One clock: check what is due now, then drive the next input
task automatic run_cycle(input logic stb, input ex_pkg::ex_inst_t ins);
    exp_store_t e;
    @(posedge clk);
    #1;
    cyc++;
    check_flags(flags_d2);
    e = '0;
    if (st_q.size() != 0 && st_q[0].due == 32'(cyc)) e = st_q.pop_front();
    check_store(e.addr, e.st);
    inst_stb = stb;
    inst = ins;
    if (stb) model_exec(ins);
    flags_d2 = flags_d1;
    flags_d1 = model_flags;
endtask

task automatic dump_all();
    logic [15:0] w;
    for (int i = 0; i < 16; i++) begin
        dmp_addr = 4'(i);
        w = model_regs[3'(i >> 1)];
        #1;
        check_dump(4'(i), i[0] ? w[15:8] : w[7:0]);
    end
endtask

initial begin
    ex_pkg::ex_inst_t ins;
    logic [2:0]       prev_dst;
    int               n;
    inst_stb = 1'b0;
    inst = '0;
    dmp_addr = '0;
    lfsr = 32'h196f;
    cyc = 0;
    model_flags = '0;
    flags_d1 = '0;
    flags_d2 = '0;
    for (int i = 0; i < 8; i++) model_regs[i] = '0;
    n = 0;
    while (reset !== 1'b0) begin
        @(posedge clk);
        n++;
        if (n > 40) begin
            $display("Reset was never released");
            stop_sim();
        end
    end
    #1;
    check_flags('0);
    check_store('0, '0);
    dump_all();
    // Random stream with gaps in the strobe
    repeat (400) begin
        ins = rand_inst();
        run_cycle(take_bits(2) != 0, ins);
    end
    // Strobe every cycle, each source is the previous destination
    prev_dst = 3'd0;
    repeat (300) begin
        ins = rand_inst();
        ins.src = prev_dst;
        prev_dst = ins.dst;
        run_cycle(1'b1, ins);
    end
    n = 0;
    while (st_q.size() != 0 || n < 4) begin
        run_cycle(1'b0, '0);
        n++;
        if (n > 20) begin
            $display("Pipeline did not drain the expected stores");
            stop_sim();
        end
    end
    dump_all();
    $display("Simulation completed successfully");
    $finish;
end

endmodule

/* flist.f */
verilog/ex_pkg.sv
verilog/ex_regs.sv
verilog/ex_alu.sv
verilog/ex_idxaddr.sv
verilog/ex_wb.sv
verilog/ex_core.sv
verif/tb_ex_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ex_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module tb_ex_core -Mdir obj_dir -o sim_ex_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_ex_core > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Testbench reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "Run finished without failure"
exit 0
